// ==== Bender.yml ====
package:
  name: isect

sources:
  # package first, then leaf modules, then the top level
  - files:
      - hdl/isect_pkg.sv
      - hdl/ray_decode.sv
      - hdl/isect_execute.sv
      - hdl/pixel_result.sv
      - hdl/isect_top.sv

  # testbench, top module tb_isect
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_isect.sv

// ==== all.f ====
hdl/isect_pkg.sv
hdl/ray_decode.sv
hdl/isect_execute.sv
hdl/pixel_result.sv
hdl/isect_top.sv
sim/clk_gen.sv
sim/tb_isect.sv

// ==== hdl/isect_execute.sv ====
/*
  intersection execute, two stages
  stage 1 edge functions per triangle, stage 2 hit test and nearest pick
*/
module isect_execute #(
  parameter int NUM_TRI = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          full,
  input  logic                          dec_valid,
  input  isect_pkg::ray_t               dec_ray,
  input  isect_pkg::tri_t [NUM_TRI-1:0] dec_scene,
  output logic                          exe_valid,
  output logic [7:0]                    exe_ray_id,
  output logic                          exe_hit,
  output logic [2:0]                    exe_tri_idx,
  output isect_pkg::color_t             exe_color
);
  import isect_pkg::*;

  typedef logic signed [EDGE_W-1:0] edge_t;

  // stage 2 view of a triangle without its vertices
  typedef struct packed {
    logic   valid;
    depth_t depth;
    color_t color;
    edge_t  e0;  // v0 -> v1
    edge_t  e1;  // v1 -> v2
    edge_t  e2;  // v2 -> v0
  } tri_eval_t;

  // cross product of edge a->b with a->p
  function automatic edge_t edge_fn(vert_t a, vert_t b, coord_t px, coord_t py);
    edge_t ex;
    edge_t ey;
    edge_t qx;
    edge_t qy;
    ex = edge_t'(b.x) - edge_t'(a.x);  // sign extended differences fit 9b
    ey = edge_t'(b.y) - edge_t'(a.y);
    qx = edge_t'(px) - edge_t'(a.x);
    qy = edge_t'(py) - edge_t'(a.y);
    return (ex * qy) - (ey * qx);
  endfunction

  tri_eval_t [NUM_TRI-1:0] eval_d;
  tri_eval_t [NUM_TRI-1:0] eval_q;
  logic                    s1_valid;
  ray_t                    s1_ray;

  // stage 1
  always_comb begin
    for (int i = 0; i < NUM_TRI; i++) begin
      eval_d[i].valid = dec_scene[i].valid;
      eval_d[i].depth = dec_scene[i].depth;
      eval_d[i].color = dec_scene[i].color;
      eval_d[i].e0    = edge_fn(dec_scene[i].v0, dec_scene[i].v1, dec_ray.x, dec_ray.y);
      eval_d[i].e1    = edge_fn(dec_scene[i].v1, dec_scene[i].v2, dec_ray.x, dec_ray.y);
      eval_d[i].e2    = edge_fn(dec_scene[i].v2, dec_scene[i].v0, dec_ray.x, dec_ray.y);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      s1_valid <= 1'b0;
    else if (!full)
      s1_valid <= dec_valid;
  end

  always_ff @(posedge clk) begin
    if (!full) begin
      eval_q <= eval_d;
      s1_ray <= dec_ray;
    end
  end

  // stage 2
  logic [NUM_TRI-1:0] in_tri;   // point inside or on an edge
  logic [NUM_TRI-1:0] hit_vec;
  logic               any_hit;
  logic [2:0]         best_idx;
  depth_t             best_depth;
  color_t             best_color;

  always_comb begin
    any_hit    = 1'b0;
    best_idx   = '0;
    best_depth = '1;
    best_color = '0;
    for (int i = 0; i < NUM_TRI; i++) begin
      // either winding counts and zero is inside
      in_tri[i] = (eval_q[i].e0 >= 0 && eval_q[i].e1 >= 0 && eval_q[i].e2 >= 0) ||
                  (eval_q[i].e0 <= 0 && eval_q[i].e1 <= 0 && eval_q[i].e2 <= 0);
      hit_vec[i] = eval_q[i].valid && in_tri[i] && (eval_q[i].depth < s1_ray.t_max);
      // strict less keeps the lowest index on equal depth
      if (hit_vec[i] && (!any_hit || eval_q[i].depth < best_depth)) begin
        any_hit    = 1'b1;
        best_idx   = 3'(i);
        best_depth = eval_q[i].depth;
        best_color = eval_q[i].color;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_valid <= 1'b0;
      exe_hit   <= 1'b0;
    end else if (!full) begin
      exe_valid <= s1_valid;
      exe_hit   <= s1_valid && any_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (!full) begin
      exe_ray_id  <= s1_ray.ray_id;
      exe_tri_idx <= best_idx;
      exe_color   <= best_color;
    end
  end

endmodule

// ==== hdl/isect_pkg.sv ====
/*
  intersection package
  fixed-point coordinates, triangles, the two-way command word,
  rays in flight and pixel-buffer entries
*/
package isect_pkg;

  localparam int COORD_W = 8;   // signed screen coordinate
  localparam int EDGE_W  = 18;  // fits a difference of two 9b x 9b products
  localparam int MAX_TRI = 8;   // reach of the 3b slot field

  typedef logic signed [COORD_W-1:0] coord_t;
  typedef logic [7:0]  depth_t;  // larger is further away
  typedef logic [23:0] color_t;  // rgb 8:8:8

  typedef struct packed {
    coord_t x;
    coord_t y;
  } vert_t;

  // one scene slot, 81b
  typedef struct packed {
    logic   valid;  // clear = slot empty
    vert_t  v0;
    vert_t  v1;
    vert_t  v2;
    depth_t depth;  // constant-depth plane
    color_t color;  // flat color
  } tri_t;

  // ray flavour of the payload, padded out to the load size
  typedef struct packed {
    logic [7:0]  ray_id;
    coord_t      x;
    coord_t      y;
    depth_t      t_max;  // hits must be strictly nearer
    logic [51:0] pad;    // 84 - 32
  } ray_cmd_t;

  // load flavour, 84b
  typedef struct packed {
    logic [$clog2(MAX_TRI)-1:0] slot;
    tri_t                       triangle;
  } load_cmd_t;

  // same 84 bits, read as ray or as load depending on op
  typedef union packed {
    ray_cmd_t  ray;
    load_cmd_t load;
  } cmd_payload_u;

  typedef enum logic {
    OP_RAY  = 1'b0,
    OP_LOAD = 1'b1
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e      op;
    cmd_payload_u payload;
  } cmd_t;  // 85b

  // ray token through the pipe, 32b
  typedef struct packed {
    logic [7:0] ray_id;
    coord_t     x;
    coord_t     y;
    depth_t     t_max;
  } ray_t;

  // pixel-buffer entry, 36b
  typedef struct packed {
    logic [7:0] ray_id;
    logic       hit;
    logic [2:0] tri_idx;  // zero on a miss
    color_t     color;    // zero on a miss
  } pixel_entry_t;

endpackage

// ==== hdl/isect_top.sv ====
/*
  ray-triangle intersection top
  decode, execute and result in a fixed four-cycle pipe
*/
module isect_top #(
  parameter int NUM_TRI = 4  // 1 .. MAX_TRI
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  input  isect_pkg::cmd_t         cmd,
  input  logic                    full,             // stalls every stage
  output logic                    we,
  output isect_pkg::pixel_entry_t pixel_entry_out
);
  import isect_pkg::*;

  // decode -> execute
  logic               dec_valid;
  ray_t               dec_ray;
  tri_t [NUM_TRI-1:0] dec_scene;

  // execute -> result
  logic               exe_valid;
  logic [7:0]         exe_ray_id;
  logic               exe_hit;
  logic [2:0]         exe_tri_idx;
  color_t             exe_color;

  ray_decode #(.NUM_TRI(NUM_TRI)) u_decode (
    .clk, .rst_n, .cmd_valid, .cmd, .full,
    .dec_valid, .dec_ray, .dec_scene
  );

  isect_execute #(.NUM_TRI(NUM_TRI)) u_execute (
    .clk, .rst_n, .full,
    .dec_valid, .dec_ray, .dec_scene,
    .exe_valid, .exe_ray_id, .exe_hit, .exe_tri_idx, .exe_color
  );

  pixel_result u_result (
    .clk, .rst_n, .full,
    .exe_valid, .exe_ray_id, .exe_hit, .exe_tri_idx, .exe_color,
    .we, .pixel_entry_out
  );

endmodule

// ==== hdl/pixel_result.sv ====
/*
  result stage
  builds the pixel entry and strobes it into the pixel buffer
*/
module pixel_result (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   full,
  input  logic                   exe_valid,
  input  logic [7:0]             exe_ray_id,
  input  logic                   exe_hit,
  input  logic [2:0]             exe_tri_idx,
  input  isect_pkg::color_t      exe_color,
  output logic                   we,               // one cycle per ray
  output isect_pkg::pixel_entry_t pixel_entry_out
);
  import isect_pkg::*;

  pixel_entry_t entry_d;

  // misses carry index and color zero
  always_comb begin
    entry_d.ray_id  = exe_ray_id;
    entry_d.hit     = exe_hit;
    entry_d.tri_idx = exe_hit ? exe_tri_idx : '0;
    entry_d.color   = exe_hit ? exe_color : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      we <= 1'b0;
    else if (full)
      we <= 1'b0;  // ray stays parked in execute
    else
      we <= exe_valid;
  end

  always_ff @(posedge clk) begin
    if (!full && exe_valid)
      pixel_entry_out <= entry_d;  // held while full or idle
  end

endmodule

// ==== hdl/ray_decode.sv ====
/*
  command decode stage
  loads write the scene table, rays leave with a copy of it
*/
module ray_decode #(
  parameter int NUM_TRI = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cmd_valid,  // one strobe per command
  input  isect_pkg::cmd_t               cmd,
  input  logic                          full,
  output logic                          dec_valid,
  output isect_pkg::ray_t               dec_ray,
  output isect_pkg::tri_t [NUM_TRI-1:0] dec_scene   // snapshot at accept time
);
  import isect_pkg::*;

  if (NUM_TRI < 1 || NUM_TRI > MAX_TRI) begin : g_num_tri_chk
    $error("NUM_TRI %0d outside 1..%0d", NUM_TRI, MAX_TRI);
  end

  logic [NUM_TRI-1:0] tri_vld;    // per-slot valid, cleared on reset
  tri_t [NUM_TRI-1:0] tri_tab;    // slot contents
  tri_t [NUM_TRI-1:0] cur_scene;  // table as seen by a new ray
  logic               cmd_acc;
  logic               load_acc;
  logic               ray_acc;

  assign cmd_acc  = cmd_valid && !full;
  assign load_acc = cmd_acc && (cmd.op == OP_LOAD);
  assign ray_acc  = cmd_acc && (cmd.op == OP_RAY);

  always_comb begin
    for (int i = 0; i < NUM_TRI; i++) begin
      cur_scene[i]       = tri_tab[i];
      cur_scene[i].valid = tri_vld[i];  // valid lives in the reset array
    end
  end

  // table write, slots past NUM_TRI never match
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tri_vld <= '0;
    end else begin
      for (int i = 0; i < NUM_TRI; i++) begin
        if (load_acc && cmd.payload.load.slot == i)
          tri_vld[i] <= cmd.payload.load.triangle.valid;  // clear bit removes it
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_TRI; i++) begin
      if (load_acc && cmd.payload.load.slot == i)
        tri_tab[i] <= cmd.payload.load.triangle;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      dec_valid <= 1'b0;
    else if (!full)
      dec_valid <= ray_acc;  // loads leave a bubble
  end

  // ray token plus its own copy of the scene
  always_ff @(posedge clk) begin
    if (ray_acc) begin
      dec_ray.ray_id <= cmd.payload.ray.ray_id;
      dec_ray.x      <= cmd.payload.ray.x;
      dec_ray.y      <= cmd.payload.ray.y;
      dec_ray.t_max  <= cmd.payload.ray.t_max;
      dec_scene      <= cur_scene;
    end
  end

  // upstream has no handshake, it has to watch full itself
  a_no_cmd_when_full : assert property (@(posedge clk) disable iff (!rst_n)
    full |-> !cmd_valid)
    else $error("cmd_valid raised while full");

  a_load_slot_range : assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_valid && cmd.op == OP_LOAD) |-> (cmd.payload.load.slot < NUM_TRI))
    else $error("load to slot %0d, only %0d slots", cmd.payload.load.slot, NUM_TRI);

endmodule

// ==== sim/clk_gen.sv ====
/*
  testbench clock and reset
  free-running clock, active-low reset held for a few cycles
*/
module clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // released on an edge, seen at the next one
  end

endmodule

// ==== sim/tb_isect.sv ====
/*
  intersection subsystem testbench
  directed and seeded random commands, scene model with a queue of
  expected pixel entries, latency and back-pressure checks, watchdog
*/
module tb_isect;
  timeunit 1ns;
  timeprecision 100ps;
  import isect_pkg::*;

  localparam int NUM_TRI    = 4;
  localparam int N_RAND     = 200;             // commands per random phase
  localparam int MAX_STALL  = 6;               // longest full pulse
  localparam int N_CMDS     = 2 * N_RAND + 40;
  localparam int TIMEOUT_NS = N_CMDS * (MAX_STALL + 2) * 8 + 2000;

  logic         clk;
  logic         rst_n;
  logic         cmd_valid;
  cmd_t         cmd;
  logic         full;
  logic         we;
  pixel_entry_t pixel_entry_out;

  tri_t         model_tab [NUM_TRI];  // testbench copy of the scene
  pixel_entry_t exp_q [$];
  string        name_q [$];
  int           cyc_q [$];             // drive edge of each ray
  int           stall_q [$];           // stalled edges counted at drive
  string        cur_test;
  int           cyc;
  int           stall_cnt;
  logic         full_at_edge;          // full as the last edge saw it
  int           err_cnt;
  int           other_err;
  logic [7:0]   ray_seq;
  pixel_entry_t e;

  clk_gen #(.PERIOD_NS(8), .RST_CYCLES(5)) u_clk (.clk, .rst_n);

  isect_top #(.NUM_TRI(NUM_TRI)) DUT (
    .clk, .rst_n, .cmd_valid, .cmd, .full,
    .we, .pixel_entry_out
  );

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
    end
  endtask

  function automatic int cross_at(int ax, int ay, int bx, int by, int px, int py);
    return (bx - ax) * (py - ay) - (by - ay) * (px - ax);  // edge cross point vector
  endfunction

  // nearest valid triangle under the ray and strictly in front of t_max
  function automatic pixel_entry_t model_pixel(ray_cmd_t r);
    pixel_entry_t p;
    int px;
    int py;
    int c0;
    int c1;
    int c2;
    int best_d;
    tri_t t;
    p = '0;
    p.ray_id = r.ray_id;
    px = int'($signed(r.x));
    py = int'($signed(r.y));
    best_d = 256;
    for (int i = 0; i < NUM_TRI; i++) begin
      t  = model_tab[i];
      c0 = cross_at($signed(t.v0.x), $signed(t.v0.y), $signed(t.v1.x), $signed(t.v1.y), px, py);
      c1 = cross_at($signed(t.v1.x), $signed(t.v1.y), $signed(t.v2.x), $signed(t.v2.y), px, py);
      c2 = cross_at($signed(t.v2.x), $signed(t.v2.y), $signed(t.v0.x), $signed(t.v0.y), px, py);
      if (t.valid && ((c0 >= 0 && c1 >= 0 && c2 >= 0) || (c0 <= 0 && c1 <= 0 && c2 <= 0))
          && t.depth < r.t_max && int'(t.depth) < best_d) begin
        best_d    = t.depth;  // strict less so the lowest index wins ties
        p.hit     = 1'b1;
        p.tri_idx = 3'(i);
        p.color   = t.color;
      end
    end
    return p;
  endfunction

  function automatic tri_t make_tri(int x0, int y0, int x1, int y1, int x2, int y2,
                                    int depth, logic [23:0] color, logic valid);
    tri_t t;
    t.valid = valid;
    t.v0.x  = coord_t'(x0);
    t.v0.y  = coord_t'(y0);
    t.v1.x  = coord_t'(x1);
    t.v1.y  = coord_t'(y1);
    t.v2.x  = coord_t'(x2);
    t.v2.y  = coord_t'(y2);
    t.depth = depth_t'(depth);
    t.color = color;
    return t;
  endfunction

  function automatic int rand_coord();
    return int'($urandom_range(15)) - 8;  // small window makes hits common
  endfunction

  // one edge of stimulus with the model updated in drive order
  task automatic drive_cycle(input logic v, input cmd_t c, input logic f,
                             output pixel_entry_t exp_e);
    exp_e = '0;
    @(posedge clk);
    if (v && f) begin
      other_err++;
      $display("testbench tried to send a command while full was high");
    end
    cmd_valid <= v;
    cmd       <= c;
    full      <= f;
    if (v && c.op == OP_LOAD) begin
      model_tab[c.payload.load.slot] = c.payload.load.triangle;
    end else if (v) begin
      exp_e = model_pixel(c.payload.ray);
      exp_q.push_back(exp_e);
      name_q.push_back(cur_test);
      cyc_q.push_back(cyc + 1);
      stall_q.push_back(stall_cnt + int'(full));  // full sampled at this edge
    end
  endtask

  task automatic idle(input int n, input logic f);
    pixel_entry_t dummy;
    repeat (n) drive_cycle(1'b0, cmd, f, dummy);
  endtask

  task automatic send_load(input int slot, input tri_t t);
    cmd_t         c;
    pixel_entry_t dummy;
    c = '0;
    c.op = OP_LOAD;
    c.payload.load.slot     = 3'(slot);
    c.payload.load.triangle = t;
    drive_cycle(1'b1, c, 1'b0, dummy);
  endtask

  task automatic send_ray(input int x, input int y, input int t_max,
                          output pixel_entry_t exp_e);
    cmd_t c;
    c = '0;
    c.op = OP_RAY;
    c.payload.ray.ray_id = ray_seq;
    c.payload.ray.x      = coord_t'(x);
    c.payload.ray.y      = coord_t'(y);
    c.payload.ray.t_max  = depth_t'(t_max);
    ray_seq++;
    drive_cycle(1'b1, c, 1'b0, exp_e);
  endtask

  task automatic rand_phase(input int n, input bit with_full);
    pixel_entry_t dummy;
    for (int k = 0; k < n; k++) begin
      if (with_full && $urandom_range(2) == 0)
        idle($urandom_range(MAX_STALL, 1), 1'b1);  // full pulse without commands
      if ($urandom_range(7) == 0)
        idle(1, 1'b0);
      if ($urandom_range(9) < 4)
        send_load($urandom_range(NUM_TRI - 1),
                  make_tri(rand_coord(), rand_coord(), rand_coord(), rand_coord(),
                           rand_coord(), rand_coord(), $urandom_range(63),
                           24'($urandom), $urandom_range(7) != 0));
      else
        send_ray(rand_coord(), rand_coord(), $urandom_range(80), dummy);
    end
  endtask

  // outputs sampled on the falling edge away from the drive edge
  always @(negedge clk) begin : monitor
    pixel_entry_t x;
    string        nm;
    int           lat;
    if (rst_n) begin
      cyc++;
      if (full_at_edge)
        stall_cnt++;
      if (we && full_at_edge) begin
        other_err++;
        $display("write strobe right after an edge with full high");
      end
      if (we && exp_q.size() == 0) begin
        other_err++;
        $display("write strobe with no ray outstanding");
      end else if (we) begin
        x   = exp_q.pop_front();
        nm  = name_q.pop_front();
        lat = cyc - cyc_q.pop_front();
        check_val({nm, " ray_id"}, x.ray_id, pixel_entry_out.ray_id);
        check_val({nm, " hit"}, x.hit, pixel_entry_out.hit);
        check_val({nm, " tri_idx"}, x.tri_idx, pixel_entry_out.tri_idx);
        check_val({nm, " color"}, x.color, pixel_entry_out.color);
        check_val({nm, " latency"}, 4 + stall_cnt - stall_q.pop_front(), lat);
      end
      full_at_edge = full;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, pipeline stopped writing entries", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : stimulus
    int left;
    void'($urandom(89));
    cmd_valid    = 1'b0;
    cmd          = '0;
    full         = 1'b0;
    full_at_edge = 1'b0;
    cyc          = 0;
    stall_cnt    = 0;
    err_cnt      = 0;
    other_err    = 0;
    ray_seq      = '0;
    for (int i = 0; i < NUM_TRI; i++)
      model_tab[i] = '0;  // empty scene after reset
    wait (rst_n);

    cur_test = "reset";
    idle(10, 1'b0);                       // no strobe expected here
    send_ray(0, 0, 255, e);
    idle(6, 1'b0);

    cur_test = "nearest";
    send_load(0, make_tri(-8, -8, 7, -8, 0, 7, 40, 24'h110000, 1'b1));
    send_load(1, make_tri(-8, -8, 7, -8, 0, 7, 20, 24'h002200, 1'b1));
    send_load(2, make_tri(0, 7, 7, -8, -8, -8, 20, 24'h000033, 1'b1));  // other winding
    send_load(3, make_tri(-8, -8, 7, -8, 0, 7, 30, 24'h444444, 1'b1));
    send_ray(0, 0, 255, e);
    check_val("nearest model idx", 1, e.tri_idx);
    send_ray(7, -8, 255, e);              // on a vertex
    check_val("vertex model idx", 1, e.tri_idx);
    send_ray(7, 7, 255, e);               // outside all four
    check_val("outside model hit", 0, e.hit);

    cur_test = "depth";
    send_ray(0, 0, 20, e);                // depth equal to t_max misses
    check_val("t_max model hit", 0, e.hit);
    send_ray(0, 0, 21, e);
    check_val("t_max+1 model idx", 1, e.tri_idx);
    send_load(1, make_tri(-8, -8, 7, -8, 0, 7, 20, 24'h002200, 1'b0));
    send_ray(0, 0, 255, e);
    check_val("removed model idx", 2, e.tri_idx);

    cur_test = "load order";
    send_ray(0, 0, 255, e);
    check_val("before load model idx", 2, e.tri_idx);
    send_load(3, make_tri(-8, -8, 7, -8, 0, 7, 5, 24'h00aa00, 1'b1));
    send_ray(0, 0, 255, e);
    check_val("after load model idx", 3, e.tri_idx);
    idle(6, 1'b0);

    cur_test = "random";
    rand_phase(N_RAND, 1'b0);
    idle(6, 1'b0);

    cur_test = "backpressure";
    rand_phase(N_RAND, 1'b1);
    idle(12, 1'b0);                       // drain

    left = exp_q.size();
    if (left != 0) begin
      other_err++;
      $display("%0d expected entries were never written", left);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d entries unmatched",
             err_cnt, other_err, left);
    if (err_cnt == 0 && other_err == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
